// File: verilog/frogger_geom_pkg.sv
//------------------------------------------------
// frogger playfield geometry
// coordinate types, object sizes, scenery bands
//------------------------------------------------
package frogger_geom_pkg;

	typedef logic [10:0] coord_t; // one screen axis
	typedef logic [2:0]  count_t; // active objects in a row

	localparam int DEF_ROWS  = 4; // lanes and pad rows
	localparam int DEF_SLOTS = 4; // objects per row

	//------------------------------------------------
	// object boxes
	//------------------------------------------------
	localparam coord_t FROG_SIZE         = 11'd40;
	localparam coord_t FROG_INSET_LEFT   = 11'd7;
	localparam coord_t FROG_INSET_RIGHT  = 11'd7;
	localparam coord_t FROG_INSET_TOP    = 11'd10;
	localparam coord_t FROG_INSET_BOTTOM = 11'd5;
	localparam coord_t CAR_W             = 11'd80;
	localparam coord_t CAR_H             = 11'd40;
	localparam coord_t LPAD_SIZE         = 11'd40;
	localparam coord_t WRAP_X            = 11'd680; // at or above, hanging off the left edge

	//------------------------------------------------
	// scenery bands, all bounds inclusive
	//------------------------------------------------
	localparam coord_t WATER_Y_LO     = 11'd80;
	localparam coord_t WATER_Y_HI     = 11'd239;
	localparam coord_t TOP_Y_LO       = 11'd40;
	localparam coord_t TOP_Y_HI       = 11'd79;
	localparam coord_t GRASS_Y_LO     = 11'd240;
	localparam coord_t GRASS_Y_HI     = 11'd279;
	localparam coord_t LOW_GRASS_Y_LO = 11'd440; // grass down to the bottom
	localparam coord_t PAVE_Y_LO      = 11'd280;
	localparam coord_t PAVE_Y_HI      = 11'd439;

	// column sets inside the top strip, entry 0 leftmost
	localparam coord_t [3:0] DARK_X_LO  = {11'd520, 11'd320, 11'd160, 11'd0};
	localparam coord_t [3:0] DARK_X_HI  = {11'd679, 11'd479, 11'd279, 11'd119};
	localparam coord_t [2:0] GRASS_X_LO = {11'd480, 11'd280, 11'd120};
	localparam coord_t [2:0] GRASS_X_HI = {11'd519, 11'd319, 11'd159};

	// construction stripes on the road
	localparam coord_t [2:0] STRIPE_Y_LO = {11'd398, 11'd358, 11'd318};
	localparam coord_t [2:0] STRIPE_Y_HI = {11'd402, 11'd362, 11'd322};
	localparam coord_t [3:0] STRIPE_X_LO = {11'd600, 11'd400, 11'd200, 11'd0};
	localparam coord_t [3:0] STRIPE_X_HI = {11'd2047, 11'd500, 11'd300, 11'd100}; // last open

endpackage

// File: verilog/frogger_color_pkg.sv
//------------------------------------------------
// frogger colours
// channel type and the colour of every layer
//------------------------------------------------
package frogger_color_pkg;

	typedef logic [7:0] chan_t;  // one vga channel
	typedef chan_t [2:0] rgb_t;  // [2] red, [1] green, [0] blue

	//------------------------------------------------
	// object layers
	//------------------------------------------------
	localparam rgb_t COL_FROG     = {8'd128, 8'd255, 8'd0};
	localparam rgb_t COL_CAR_EVEN = {8'd200, 8'd0,   8'd0};   // lanes 0 and 2
	localparam rgb_t COL_CAR_ODD  = {8'd0,   8'd0,   8'd200}; // lanes 1 and 3
	localparam rgb_t COL_LPAD     = {8'd0,   8'd250, 8'd0};

	//------------------------------------------------
	// scenery
	//------------------------------------------------
	localparam rgb_t COL_WATER      = {8'd0,   8'd200, 8'd255};
	localparam rgb_t COL_DARK_GRASS = {8'd0,   8'd100, 8'd0};
	localparam rgb_t COL_GRASS      = {8'd0,   8'd200, 8'd0};
	localparam rgb_t COL_STRIPE     = {8'd255, 8'd204, 8'd0};   // construction yellow
	localparam rgb_t COL_PAVEMENT   = {8'd69,  8'd69,  8'd69};
	localparam rgb_t COL_WHITE      = {8'd255, 8'd255, 8'd255};

endpackage

// File: verilog/layer_ifs.sv
//------------------------------------------------
// layer buses into the priority mixer
// object hit flags and scenery colour, one pixel each
//------------------------------------------------
`timescale 1ns/1ps

// hit flags of the object layers
interface obj_hit_if #(
	parameter int N_ROWS = frogger_geom_pkg::DEF_ROWS
);
	logic              valid;    // flags below belong to one pixel
	logic              frog_hit;
	logic [N_ROWS-1:0] car_hit;  // one per lane
	logic              lpad_hit; // any pad in any row

	modport detect (
		output valid, frog_hit, car_hit, lpad_hit
	);

	modport mix (
		input valid, frog_hit, car_hit, lpad_hit
	);
endinterface

// scenery colour under the objects
interface bg_color_if;
	logic                     valid;
	frogger_color_pkg::chan_t red;
	frogger_color_pkg::chan_t green;
	frogger_color_pkg::chan_t blue;

	modport source (
		output valid, red, green, blue
	);

	modport mix (
		input valid, red, green, blue
	);
endinterface

// File: verilog/sprite_hit_detect.sv
//------------------------------------------------
// object hit detection
// frog, car lanes and lily pads against the pixel
//------------------------------------------------
`timescale 1ns/1ps

module sprite_hit_detect #(
	parameter int N_ROWS  = frogger_geom_pkg::DEF_ROWS,
	parameter int N_SLOTS = frogger_geom_pkg::DEF_SLOTS
) (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  frogger_geom_pkg::coord_t draw_x,
	input  frogger_geom_pkg::coord_t draw_y,
	input  frogger_geom_pkg::coord_t frog_x,
	input  frogger_geom_pkg::coord_t frog_y,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] car_x,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] car_y,
	input  frogger_geom_pkg::count_t [N_ROWS-1:0] car_count,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] lpad_x,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] lpad_y,
	input  frogger_geom_pkg::count_t [N_ROWS-1:0] lpad_count,
	obj_hit_if.detect hit
);

	import frogger_geom_pkg::*;

	// box test shared by cars and pads
	function automatic logic box_hit(
		coord_t px,
		coord_t py,
		coord_t ox,
		coord_t oy,
		coord_t w,
		coord_t h
	);
		coord_t x_lo;
		coord_t x_hi;
		coord_t y_hi;

		x_lo = (ox < WRAP_X) ? ox : '0; // wrapped object starts at the left edge
		x_hi = ox + w;                   // 11 bit sum, wraps past 2047
		y_hi = oy + h;
		return (px >= x_lo) && (px <= x_hi) && (py >= oy) && (py <= y_hi);
	endfunction

	coord_t frog_x_lo;
	coord_t frog_x_hi;
	coord_t frog_y_lo;
	coord_t frog_y_hi;

	logic              frog_d;
	logic [N_ROWS-1:0] car_hit_d;
	logic              lpad_hit_d;

	//------------------------------------------------
	// frog, inset inside its 40x40 tile
	//------------------------------------------------
	assign frog_x_lo = frog_x + FROG_INSET_LEFT;
	assign frog_x_hi = frog_x + FROG_SIZE - FROG_INSET_RIGHT;
	assign frog_y_lo = frog_y + FROG_INSET_TOP;
	assign frog_y_hi = frog_y + FROG_SIZE - FROG_INSET_BOTTOM;

	assign frog_d = (draw_x >= frog_x_lo) && (draw_x <= frog_x_hi) &&
		(draw_y >= frog_y_lo) && (draw_y <= frog_y_hi);

	//------------------------------------------------
	// cars per lane, pads over all rows
	//------------------------------------------------
	always_comb
	begin
		car_hit_d  = '0;
		lpad_hit_d = 1'b0;
		for (int r = 0; r < N_ROWS; r++)
		begin
			for (int s = 0; s < N_SLOTS; s++)
			begin
				// slots past the row count are parked
				if (s < int'(car_count[r]) &&
					box_hit(draw_x, draw_y, car_x[r][s], car_y[r][s], CAR_W, CAR_H))
					car_hit_d[r] = 1'b1;
				if (s < int'(lpad_count[r]) &&
					box_hit(draw_x, draw_y, lpad_x[r][s], lpad_y[r][s], LPAD_SIZE, LPAD_SIZE))
					lpad_hit_d = 1'b1;
			end
		end
	end

	//------------------------------------------------
	// output register
	//------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			hit.valid <= 1'b0;
		else
			hit.valid <= pix_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			hit.frog_hit <= frog_d;
			hit.car_hit  <= car_hit_d;
			hit.lpad_hit <= lpad_hit_d;
		end
	end

endmodule

// File: verilog/playfield_background.sv
//------------------------------------------------
// playfield scenery
// water, grass, road and stripes by position
//------------------------------------------------
`timescale 1ns/1ps

module playfield_background (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  frogger_geom_pkg::coord_t draw_x,
	input  frogger_geom_pkg::coord_t draw_y,
	bg_color_if.source bg
);

	import frogger_geom_pkg::*;
	import frogger_color_pkg::*;

	function automatic logic in_range(coord_t v, coord_t lo, coord_t hi);
		return (v >= lo) && (v <= hi);
	endfunction

	logic top_strip;
	logic dark_col;
	logic grass_col;
	logic stripe_row;
	logic stripe_col;
	rgb_t col_d;

	//------------------------------------------------
	// band membership
	//------------------------------------------------
	assign top_strip = in_range(draw_y, TOP_Y_LO, TOP_Y_HI);

	always_comb
	begin
		dark_col   = 1'b0;
		grass_col  = 1'b0;
		stripe_row = 1'b0;
		stripe_col = 1'b0;
		for (int i = 0; i < $size(DARK_X_LO); i++)
			dark_col |= in_range(draw_x, DARK_X_LO[i], DARK_X_HI[i]);
		for (int i = 0; i < $size(GRASS_X_LO); i++)
			grass_col |= in_range(draw_x, GRASS_X_LO[i], GRASS_X_HI[i]);
		for (int i = 0; i < $size(STRIPE_Y_LO); i++)
			stripe_row |= in_range(draw_y, STRIPE_Y_LO[i], STRIPE_Y_HI[i]);
		for (int i = 0; i < $size(STRIPE_X_LO); i++)
			stripe_col |= in_range(draw_x, STRIPE_X_LO[i], STRIPE_X_HI[i]);
	end

	// first match wins
	always_comb
	begin
		if (in_range(draw_y, WATER_Y_LO, WATER_Y_HI))
			col_d = COL_WATER;
		else if (top_strip && dark_col)
			col_d = COL_DARK_GRASS;
		else if (in_range(draw_y, GRASS_Y_LO, GRASS_Y_HI) || (draw_y >= LOW_GRASS_Y_LO) ||
			(top_strip && grass_col))
			col_d = COL_GRASS;
		else if (stripe_row && stripe_col)
			col_d = COL_STRIPE;
		else if (in_range(draw_y, PAVE_Y_LO, PAVE_Y_HI))
			col_d = COL_PAVEMENT;
		else
			col_d = COL_WHITE; // score bar and right margin
	end

	//------------------------------------------------
	// output register
	//------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			bg.valid <= 1'b0;
		else
			bg.valid <= pix_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pix_valid)
		begin
			bg.red   <= col_d[2];
			bg.green <= col_d[1];
			bg.blue  <= col_d[0];
		end
	end

endmodule

// File: verilog/pixel_priority_mixer.sv
//------------------------------------------------
// layer priority mixer
// frog, then cars, then pads, then scenery
//------------------------------------------------
`timescale 1ns/1ps

module pixel_priority_mixer #(
	parameter int N_ROWS = frogger_geom_pkg::DEF_ROWS
) (
	input  logic clk,
	input  logic rst,
	obj_hit_if.mix hit,
	bg_color_if.mix bg,
	output logic rgb_valid,
	output frogger_color_pkg::chan_t red,
	output frogger_color_pkg::chan_t green,
	output frogger_color_pkg::chan_t blue
);

	import frogger_color_pkg::*;

	logic in_valid;
	rgb_t car_col;
	rgb_t mix_col;

	assign in_valid = hit.valid & bg.valid; // both branches run in lockstep

	// lowest lane that hits picks the colour
	always_comb
	begin
		car_col = COL_CAR_EVEN;
		for (int r = N_ROWS - 1; r >= 0; r--)
		begin
			if (hit.car_hit[r])
				car_col = (r % 2 == 1) ? COL_CAR_ODD : COL_CAR_EVEN;
		end
	end

	always_comb
	begin
		if (hit.frog_hit)
			mix_col = COL_FROG;
		else if (|hit.car_hit)
			mix_col = car_col;
		else if (hit.lpad_hit)
			mix_col = COL_LPAD;
		else
			mix_col = {bg.red, bg.green, bg.blue};
	end

	//------------------------------------------------
	// vga output register
	//------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rgb_valid <= 1'b0;
			red       <= '0;
			green     <= '0;
			blue      <= '0;
		end
		else
		begin
			rgb_valid <= in_valid;
			if (in_valid) // hold last colour between pixels
			begin
				red   <= mix_col[2];
				green <= mix_col[1];
				blue  <= mix_col[0];
			end
		end
	end

endmodule

// File: verilog/color_mapper.sv
//------------------------------------------------
// frogger colour mapper
// two-stage pixel pipeline from position to rgb
//------------------------------------------------
`timescale 1ns/1ps

module color_mapper #(
	parameter int N_ROWS  = frogger_geom_pkg::DEF_ROWS,
	parameter int N_SLOTS = frogger_geom_pkg::DEF_SLOTS
) (
	input  logic clk,
	input  logic rst,
	input  logic pix_valid,
	input  frogger_geom_pkg::coord_t draw_x,
	input  frogger_geom_pkg::coord_t draw_y,
	input  frogger_geom_pkg::coord_t frog_x,
	input  frogger_geom_pkg::coord_t frog_y,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] car_x,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] car_y,
	input  frogger_geom_pkg::count_t [N_ROWS-1:0] car_count,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] lpad_x,
	input  frogger_geom_pkg::coord_t [N_ROWS-1:0][N_SLOTS-1:0] lpad_y,
	input  frogger_geom_pkg::count_t [N_ROWS-1:0] lpad_count,
	output logic rgb_valid,
	output frogger_color_pkg::chan_t red,
	output frogger_color_pkg::chan_t green,
	output frogger_color_pkg::chan_t blue
);

	obj_hit_if #(.N_ROWS(N_ROWS)) hit_bus ();
	bg_color_if bg_bus ();

	// stage 1, objects and scenery side by side
	sprite_hit_detect #(
		.N_ROWS  (N_ROWS),
		.N_SLOTS (N_SLOTS)
	) i_sprite_hit_detect (
		.clk        (clk),
		.rst        (rst),
		.pix_valid  (pix_valid),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.frog_x     (frog_x),
		.frog_y     (frog_y),
		.car_x      (car_x),
		.car_y      (car_y),
		.car_count  (car_count),
		.lpad_x     (lpad_x),
		.lpad_y     (lpad_y),
		.lpad_count (lpad_count),
		.hit        (hit_bus.detect)
	);

	playfield_background i_playfield_background (
		.clk       (clk),
		.rst       (rst),
		.pix_valid (pix_valid),
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.bg        (bg_bus.source)
	);

	// stage 2
	pixel_priority_mixer #(
		.N_ROWS (N_ROWS)
	) i_pixel_priority_mixer (
		.clk       (clk),
		.rst       (rst),
		.hit       (hit_bus.mix),
		.bg        (bg_bus.mix),
		.rgb_valid (rgb_valid),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

// File: tb/tb_pixel_model.svh
//------------------------------------------------
// pixel reference model
// expected colour from object boxes and scenery
//------------------------------------------------
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// inclusive box, objects at x 680 and up start at the left edge
function automatic logic in_box(int px, int py, int ox, int oy, int w, int h);
	int left;
	int right;
	left  = (ox >= 680) ? 0 : ox;
	right = (ox >= 680) ? (ox + w) % 2048 : ox + w; // right edge kept in 11 bits
	return px >= left && px <= right && py >= oy && py <= oy + h;
endfunction

function automatic rgb_t scenery(int x, int y);
	logic top;
	top = (y >= 40 && y <= 79);
	if (y >= 80 && y <= 239)
		return COL_WATER;
	if (top && (x <= 119 || (x >= 160 && x <= 279) || (x >= 320 && x <= 479) ||
		(x >= 520 && x <= 679)))
		return COL_DARK_GRASS;
	if ((y >= 240 && y <= 279) || y >= 440 || (top && ((x >= 120 && x <= 159) ||
		(x >= 280 && x <= 319) || (x >= 480 && x <= 519))))
		return COL_GRASS;
	if (((y >= 318 && y <= 322) || (y >= 358 && y <= 362) || (y >= 398 && y <= 402)) &&
		(x <= 100 || (x >= 200 && x <= 300) || (x >= 400 && x <= 500) || x >= 600))
		return COL_STRIPE;
	if (y >= 280 && y <= 439)
		return COL_PAVEMENT;
	return COL_WHITE;
endfunction

// frog, then lowest car lane, then pads, then scenery
function automatic rgb_t expected_rgb(int px, int py);
	int   lane;
	logic pad;
	lane = -1;
	pad  = 1'b0;
	if (px >= frog_x + 7 && px <= frog_x + 33 && py >= frog_y + 10 && py <= frog_y + 35)
		return COL_FROG;
	for (int r = N_ROWS - 1; r >= 0; r--)
		for (int s = 0; s < N_SLOTS; s++)
		begin
			if (s < car_count[r] && in_box(px, py, car_x[r][s], car_y[r][s], 80, 40))
				lane = r; // lowest lane is written last
			if (s < lpad_count[r] && in_box(px, py, lpad_x[r][s], lpad_y[r][s], 40, 40))
				pad = 1'b1;
		end
	if (lane >= 0)
		return (lane % 2 == 1) ? COL_CAR_ODD : COL_CAR_EVEN;
	if (pad)
		return COL_LPAD;
	return scenery(px, py);
endfunction

`endif

// File: tb/tb_color_mapper.sv
//------------------------------------------------
// colour mapper testbench
// directed and random pixels against a model
//------------------------------------------------
`timescale 1ns/1ps

module tb_color_mapper;

	import frogger_geom_pkg::*;
	import frogger_color_pkg::*;

	localparam int N_ROWS  = DEF_ROWS;
	localparam int N_SLOTS = DEF_SLOTS;
	localparam int LATENCY = 2; // edges from drive to rgb_valid

	logic   clk;
	logic   rst;
	logic   pix_valid;
	coord_t draw_x;
	coord_t draw_y;
	coord_t frog_x;
	coord_t frog_y;
	coord_t [N_ROWS-1:0][N_SLOTS-1:0] car_x;
	coord_t [N_ROWS-1:0][N_SLOTS-1:0] car_y;
	count_t [N_ROWS-1:0] car_count;
	coord_t [N_ROWS-1:0][N_SLOTS-1:0] lpad_x;
	coord_t [N_ROWS-1:0][N_SLOTS-1:0] lpad_y;
	count_t [N_ROWS-1:0] lpad_count;
	logic   rgb_valid;
	chan_t  red;
	chan_t  green;
	chan_t  blue;

	rgb_t        exp_q[$]; // colours in flight
	int          due_q[$]; // cycle each one must show up
	int          cyc;
	string       cur_test;
	logic [15:0] lfsr;
	rgb_t        got;

	`include "tb_pixel_model.svh"

	color_mapper #(.N_ROWS(N_ROWS), .N_SLOTS(N_SLOTS)) i_color_mapper (.*);

	always #4 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic stop_run(string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// feedback from taps 16 14 13 11
	function automatic int take_bits(int n);
		int   v;
		logic fb;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = (v << 1) | int'(fb);
		end
		return v;
	endfunction

	//--------------------------------------------------
	// pixel driving and output monitor
	//--------------------------------------------------
	task automatic clear_objects();
		frog_x     = 11'd1500; // well off screen
		frog_y     = 11'd1500;
		car_x      = '0;
		car_y      = '0;
		car_count  = '0;
		lpad_x     = '0;
		lpad_y     = '0;
		lpad_count = '0;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		pix_valid = 1'b0;
	endtask

	task automatic send_pixel(int x, int y, int gap);
		@(posedge clk);
		#1;
		pix_valid = 1'b1;
		draw_x    = coord_t'(x);
		draw_y    = coord_t'(y);
		exp_q.push_back(expected_rgb(x, y));
		due_q.push_back(cyc + LATENCY);
		repeat (gap) idle_cycle();
	endtask

	task automatic await_results();
		int waited;
		idle_cycle();
		waited = 0;
		while (exp_q.size() != 0 && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
			stop_run($sformatf("timeout in %s, %0d pixels never came out", cur_test,
				exp_q.size()));
		@(posedge clk);
		#1;
	endtask

	// sampled on the falling edge away from register updates
	always @(negedge clk)
	begin
		if (rgb_valid === 1'b1)
		begin
			assert (exp_q.size() != 0)
			else stop_run($sformatf("rgb_valid came up in %s with no pixel sent", cur_test));
			got = {red, green, blue};
			assert (got === exp_q[0])
			else stop_run($sformatf("FAIL %s: rgb expected %0d %0d %0d, actual %0d %0d %0d",
				cur_test, exp_q[0][2], exp_q[0][1], exp_q[0][0], red, green, blue));
			assert (cyc == due_q[0])
			else stop_run($sformatf("FAIL %s: output cycle expected %0d, actual %0d",
				cur_test, due_q[0], cyc));
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
		end
	end

	//--------------------------------------------------
	// directed tests
	//--------------------------------------------------
	task automatic check_quiet();
		assert (rgb_valid === 1'b0)
		else stop_run("rgb_valid is not low while no pixel was sent");
		assert ({red, green, blue} === 24'd0)
		else stop_run($sformatf("FAIL %s: rgb expected 0 0 0, actual %0d %0d %0d",
			cur_test, red, green, blue));
	endtask

	task automatic reset_phase();
		cur_test = "reset";
		for (int i = 0; i < 3; i++)
		begin
			@(negedge clk);
			check_quiet();
		end
		@(posedge clk);
		#1;
		rst = 1'b0; // four edges seen with rst high
		for (int i = 0; i < 6; i++)
		begin
			@(negedge clk);
			check_quiet();
		end
	endtask

	task automatic background_bands(int gap);
		cur_test = $sformatf("background gap %0d", gap);
		clear_objects();
		send_pixel(300, 80, gap);  // water edges
		send_pixel(300, 239, gap);
		send_pixel(0, 40, gap);    // dark grass
		send_pixel(679, 79, gap);
		send_pixel(120, 60, gap);
		send_pixel(519, 60, gap);
		send_pixel(680, 60, gap);  // right of the top strip
		send_pixel(50, 240, gap);
		send_pixel(50, 279, gap);
		send_pixel(50, 440, gap);
		send_pixel(100, 318, gap); // stripe corner
		send_pixel(101, 322, gap);
		send_pixel(799, 402, gap);
		send_pixel(150, 280, gap);
		send_pixel(150, 439, gap);
		send_pixel(10, 39, gap);   // score bar
		await_results();
	endtask

	task automatic frog_insets();
		cur_test = "frog";
		clear_objects();
		car_count[0] = 3'd1;
		car_x[0][0]  = 11'd200;
		car_y[0][0]  = 11'd300;
		frog_x       = 11'd220;
		frog_y       = 11'd300;
		send_pixel(227, 320, 0); // left inset
		send_pixel(226, 320, 0);
		send_pixel(253, 320, 0); // right inset
		send_pixel(254, 320, 0);
		send_pixel(240, 310, 0);
		send_pixel(240, 309, 0);
		send_pixel(240, 335, 0);
		send_pixel(240, 336, 0);
		await_results();
	endtask

	task automatic car_lanes();
		cur_test = "cars";
		clear_objects();
		car_count[2] = 3'd1;     // slot 0 sits at the origin
		car_x[2][1]  = 11'd400;  // past the count
		car_y[2][1]  = 11'd300;
		car_count[1] = 3'd2;
		car_x[1][0]  = 11'd2030; // right edge wraps to 62
		car_y[1][0]  = 11'd360;
		car_x[1][1]  = 11'd560;
		car_y[1][1]  = 11'd300;
		car_count[0] = 3'd1;
		car_x[0][0]  = 11'd500;
		car_y[0][0]  = 11'd300;
		car_count[3] = 3'd1;
		car_x[3][0]  = 11'd100;
		car_y[3][0]  = 11'd400;
		send_pixel(420, 320, 0);
		send_pixel(0, 370, 0);
		send_pixel(62, 370, 0);
		send_pixel(63, 370, 0);
		send_pixel(570, 310, 0); // lanes 0 and 1 overlap
		send_pixel(620, 310, 0);
		send_pixel(120, 410, 0);
		send_pixel(40, 20, 0);
		await_results();
	endtask

	task automatic lily_pads();
		cur_test = "lily pads";
		clear_objects();
		lpad_count[0] = 3'd1;
		lpad_x[0][0]  = 11'd300;
		lpad_y[0][0]  = 11'd120;
		lpad_count[3] = 3'd1;
		lpad_x[3][0]  = 11'd2040; // wraps to 32
		lpad_y[3][0]  = 11'd200;
		send_pixel(320, 130, 0);
		send_pixel(0, 210, 0);
		send_pixel(32, 210, 0);
		send_pixel(33, 210, 0);
		await_results();
		car_count[2] = 3'd1;      // car across the pad
		car_x[2][0]  = 11'd290;
		car_y[2][0]  = 11'd110;
		send_pixel(320, 130, 0);
		await_results();
	endtask

	task automatic random_sweep();
		int     r;
		int     s;
		coord_t px;
		coord_t py;
		cur_test = "random";
		for (int round = 0; round < 50; round++)
		begin
			frog_x = coord_t'(take_bits(10) % 700);
			frog_y = coord_t'(take_bits(9));
			for (int i = 0; i < N_ROWS; i++)
			begin
				car_count[i]  = count_t'(take_bits(3));
				lpad_count[i] = count_t'(take_bits(3));
				for (int j = 0; j < N_SLOTS; j++)
				begin
					// one car in four hangs off the left edge
					car_x[i][j]  = (take_bits(2) == 0) ? coord_t'(1960 + take_bits(6)) :
						coord_t'(take_bits(10) % 680);
					car_y[i][j]  = coord_t'(take_bits(9));
					lpad_x[i][j] = coord_t'(take_bits(10) % 720);
					lpad_y[i][j] = coord_t'(take_bits(9));
				end
			end
			for (int p = 0; p < 4; p++)
			begin
				r = take_bits(2) % N_ROWS;
				s = take_bits(2) % N_SLOTS;
				if (p % 2 == 1) // near a car edge
				begin
					px = coord_t'(car_x[r][s] + take_bits(7) - 20);
					py = coord_t'(car_y[r][s] + take_bits(6) - 10);
				end
				else
				begin
					px = coord_t'(take_bits(10) % 800);
					py = coord_t'(take_bits(10) % 525);
				end
				send_pixel(px, py, p % 2);
			end
			await_results();
		end
	endtask

	initial
	begin
		clk       = 1'b0;
		rst       = 1'b1;
		pix_valid = 1'b0;
		draw_x    = '0;
		draw_y    = '0;
		cyc       = 0;
		lfsr      = 16'd7;
		clear_objects();
		reset_phase();
		background_bands(0);
		background_bands(1);
		background_bands(2);
		frog_insets();
		car_lanes();
		lily_pads();
		random_sweep();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: compile.f
+incdir+tb
verilog/frogger_geom_pkg.sv
verilog/frogger_color_pkg.sv
verilog/layer_ifs.sv
verilog/sprite_hit_detect.sv
verilog/playfield_background.sv
verilog/pixel_priority_mixer.sv
verilog/color_mapper.sv
tb/tb_color_mapper.sv

// File: Makefile
# Verilator build and run of the colour mapper testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_color_mapper -Mdir obj_dir -o sim_tb -f compile.f
	-./obj_dir/sim_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "result: failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" sim.log; then echo "result: no verdict"; exit 1; fi
	@echo "result: passed"

clean:
	rm -rf obj_dir sim.log
